// ==== dv/rvCoreTb.sv ====
`timescale 1ns/100ps

module rvCoreTb;

  import rvIsaPkg::*;
  import corePkg::*;

  localparam int          NumInstr       = 400;
  localparam int          ClkPeriod      = 40;
  localparam int          ResetCycles    = 4;
  localparam int          WatchdogCycles = NumInstr * 10 + ResetCycles;
  localparam logic [31:0] DataBase       = 32'h0000_0400;  // Data window above code window zero

  logic        clk;
  logic        reset;
  wbReqT       busReq;
  wbRspT       busRsp;

  logic [31:0] mem [logic [29:0]];           // Word-addressed memory shared with the model
  logic [31:0] mRegs [0:31];
  logic [31:0] known;                        // Registers that hold a defined value
  logic [31:0] mPc;
  logic [31:0] seed;
  int          valueErrors;
  int          otherErrors;
  int          retired;

  rvCore u_rvCore (
    .clk(clk),
    .reset(reset),
    .busReq(busReq),
    .busRsp(busRsp)
  );

  initial
  begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  function automatic logic [31:0] nextRand();
    seed = seed * 32'd1103515245 + 32'd12345;
    return seed;
  endfunction

  function automatic int randBelow(input int n);
    return int'((nextRand() >> 16) % n);     // Upper bits have the longer period
  endfunction

  // Picks a source register that already holds a value or falls back to x0
  function automatic logic [4:0] pickSrc();
    logic [4:0] r;
    int         i;
    for (i = 0; i < 8; i++)
    begin
      r = 5'(randBelow(32));
      if (known[r])
        return r;
    end
    return 5'd0;
  endfunction

  function automatic logic [31:0] genInstr(input logic [31:0] pc);
    int          slot;
    int          tgt;
    int          kind;
    logic [31:0] off;
    logic [31:0] addr;
    logic [31:0] rnd;
    logic [11:0] i12;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic        alt;
    slot = int'(pc[9:2]);                    // Word slot inside the 1 KB window
    kind = (slot == 255) ? 16 : randBelow(16);  // Last slot always jumps back
    tgt  = (slot == 255) ? randBelow(64) : slot + 1 + randBelow(8);
    if (tgt > 255)
      tgt = 255;
    off  = (tgt - slot) * 4;
    addr = DataBase + randBelow(256) * 4;
    if (randBelow(8) == 0)
      addr = addr + 1 + randBelow(3);        // Not word aligned
    rnd  = nextRand();
    rd   = 5'(randBelow(32));
    rs1  = pickSrc();
    rs2  = pickSrc();
    f3   = 3'(randBelow(8));
    alt  = rnd[5];
    i12  = rnd[31:20];
    case (kind)
      0, 1, 2:
      begin
        if (f3 == 3'd1 || f3 == 3'd5)
          i12 = {1'b0, alt && (f3 == 3'd5), 5'b0, rnd[28:24]};  // Shift amount
        return {i12, rs1, f3, rd, OpImm};
      end
      3, 4, 5:
        return {(alt && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00, rs2, rs1, f3, rd, Op};
      6:  return {rnd[31:12], rd, Lui};
      7:  return {rnd[31:12], rd, Auipc};
      8, 9:
      begin
        if (f3 == 3'd2 || f3 == 3'd3)
          f3 = f3 - 3'd2;                    // Unused codes become beq or bne
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], Branch};
      end
      11: return {12'(randBelow(256) * 4), 5'd0, 3'd0, rd, Jalr};  // Into window zero
      12, 13: return {addr[11:0], 5'd0, 3'b010, rd, Load};
      14, 15: return {addr[11:5], rs2, 5'd0, 3'b010, addr[4:0], Store};
      default: return {off[20], off[10:1], off[11], off[19:12], rd, Jal};
    endcase
  endfunction

  function automatic logic [31:0] arithResult(input logic [2:0] f3, input logic [31:0] a,
                                              input logic [31:0] b, input logic alt);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return {31'h0, $signed(a) < $signed(b)};
      3'd3:    return {31'h0, a < b};
      3'd4:    return a ^ b;
      3'd5:
      begin
        if (alt)
          return $signed(a) >>> b[4:0];
        return a >> b[4:0];
      end
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branchTaken(input logic [2:0] f3, input logic [31:0] a,
                                       input logic [31:0] b);
    case (f3)
      3'd0:    return a == b;
      3'd1:    return a != b;
      3'd4:    return $signed(a) < $signed(b);
      3'd5:    return $signed(a) >= $signed(b);
      3'd6:    return a < b;
      default: return a >= b;
    endcase
  endfunction

  task automatic reportMismatch(input string sigName, input logic [31:0] expVal,
                                input logic [31:0] actVal);
    valueErrors++;
    $display("** Error at %0d ns: %s expected %h, actual %h", $time, sigName, expVal, actVal);
  endtask

  // Slave side of one bus cycle between two falling edges
  task automatic serveAccess(input logic [31:0] expAddr, input logic expWe,
                             input logic [31:0] expData);
    logic [29:0] wordAdr;
    while (!(busReq.cyc === 1'b1 && busReq.stb === 1'b1))
      @(negedge clk);
    repeat (randBelow(4))
      @(negedge clk);                        // Random wait states
    wordAdr = busReq.adr;
    assert (busReq.adr == expAddr[31:2])
    else
      reportMismatch("busReq.adr", {2'b00, expAddr[31:2]}, {2'b00, busReq.adr});
    assert (busReq.we == expWe)
    else
      reportMismatch("busReq.we", {31'h0, expWe}, {31'h0, busReq.we});
    if (expWe)
    begin
      assert (busReq.datW == expData)
      else
        reportMismatch("busReq.datW", expData, busReq.datW);
    end
    busRsp.ack  = 1'b1;
    // Words outside the program read back with an illegal opcode
    busRsp.datR = mem.exists(wordAdr) ? mem[wordAdr] : {wordAdr, 2'b00};
    @(negedge clk);
    busRsp = '0;
    assert (busReq.cyc === 1'b0 && busReq.stb === 1'b0)
    else
    begin
      otherErrors++;
      $display("Bus cycle was still open one cycle after ack at %0d ns", $time);
    end
  endtask

  task automatic applyReset();
    reset = 1'b1;
    repeat (ResetCycles)
    begin
      @(posedge clk);
      @(negedge clk);
      assert (busReq.cyc === 1'b0 && busReq.stb === 1'b0)
      else
      begin
        otherErrors++;
        $display("Bus request was active while reset was held at %0d ns", $time);
      end
    end
    reset = 1'b0;
    @(negedge clk);
    assert (busReq.cyc === 1'b1 && busReq.stb === 1'b1)
    else
    begin
      otherErrors++;
      $display("First fetch did not start in the first cycle after reset");
    end
  endtask

  // Model step for one instruction that serves the bus cycles it predicts
  task automatic runOneInstr();
    logic [31:0] word;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] addr;
    logic [31:0] result;
    logic [31:0] nextPc;
    logic [4:0]  rd;
    logic        wr;
    if (!mem.exists(mPc[31:2]))
      mem[mPc[31:2]] = genInstr(mPc);        // First visit builds the program
    word = mem[mPc[31:2]];
    serveAccess(mPc, 1'b0, 32'h0);
    a      = mRegs[word[19:15]];
    b      = mRegs[word[24:20]];
    rd     = word[11:7];
    nextPc = mPc + 32'd4;
    wr     = 1'b1;
    result = 32'h0;
    case (word[6:0])
      OpImm:
        result = arithResult(word[14:12], a, {{20{word[31]}}, word[31:20]},
                             (word[14:12] == 3'd5) && word[30]);
      Op:    result = arithResult(word[14:12], a, b, word[30]);
      Lui:   result = {word[31:12], 12'h0};
      Auipc: result = mPc + {word[31:12], 12'h0};
      Jal:
      begin
        result = mPc + 32'd4;
        nextPc = mPc + {{11{word[31]}}, word[31], word[19:12], word[20], word[30:21], 1'b0};
      end
      Jalr:
      begin
        result = mPc + 32'd4;
        nextPc = (a + {{20{word[31]}}, word[31:20]}) & ~32'd1;
      end
      Branch:
      begin
        wr = 1'b0;
        if (branchTaken(word[14:12], a, b))
          nextPc = mPc + {{19{word[31]}}, word[31], word[7], word[30:25], word[11:8], 1'b0};
      end
      Load, Store:
      begin
        if (word[6:0] == Store)
          addr = a + {{20{word[31]}}, word[31:25], word[11:7]};
        else
          addr = a + {{20{word[31]}}, word[31:20]};
        if (addr[1:0] != 2'b00)              // Trap links to x1
        begin
          rd     = 5'd1;
          result = mPc;
          nextPc = TrapAddress;
        end
        else if (word[6:0] == Load)
        begin
          if (!mem.exists(addr[31:2]))
            mem[addr[31:2]] = nextRand();
          result = mem[addr[31:2]];
          serveAccess(addr, 1'b0, 32'h0);
        end
        else
        begin
          wr = 1'b0;
          serveAccess(addr, 1'b1, b);
          mem[addr[31:2]] = b;
        end
      end
      default: wr = 1'b0;
    endcase
    if (wr && rd != 5'd0)
    begin
      mRegs[rd] = result;
      known[rd] = 1'b1;
    end
    mPc = nextPc;
    retired++;
  endtask

  initial
  begin : mainSequence
    int i;
    seed        = 32'h34e1;
    reset       = 1'b1;
    busRsp      = '0;
    known       = 32'h1;                     // Only x0 is defined at start
    mPc         = ResetAddress;
    valueErrors = 0;
    otherErrors = 0;
    retired     = 0;
    for (i = 0; i < 32; i++)
      mRegs[i] = 32'h0;
    applyReset();
    repeat (NumInstr)
      runOneInstr();
    $display("Error counts: %0d value mismatches, %0d other failures", valueErrors, otherErrors);
    if (valueErrors + otherErrors == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

  initial
  begin : watchdog
    #(WatchdogCycles * ClkPeriod);
    otherErrors++;
    $display("Timeout: the core hung after %0d of %0d instructions", retired, NumInstr);
    $display("Error counts: %0d value mismatches, %0d other failures", valueErrors, otherErrors);
    $display("test failed");
    $finish;
  end

endmodule

// ==== filelist.f ====
hw/rvIsaPkg.sv
hw/corePkg.sv
hw/immDecoder.sv
hw/aluUnit.sv
hw/regBank.sv
hw/programCounter.sv
hw/controlSequencer.sv
hw/rvCore.sv
dv/rvCoreTb.sv

// ==== hw/aluUnit.sv ====
`timescale 1ns/100ps

module aluUnit (
  input  rvIsaPkg::aluOpT              aluOp,
  input  logic [rvIsaPkg::XLEN-1:0]    aluA,
  input  logic [rvIsaPkg::XLEN-1:0]    aluB,
  output logic [rvIsaPkg::XLEN-1:0]    aluResult
);

  import rvIsaPkg::*;

  logic [4:0] shamt;
  logic       cmpBit;

  assign shamt = aluB[4:0];                  // Only low five bits shift

  // Compare results used for slt and for branch decisions
  always_comb
  begin
    case (aluOp)
      Slt:     cmpBit = $signed(aluA) < $signed(aluB);
      Sltu:    cmpBit = aluA < aluB;
      Eq:      cmpBit = aluA == aluB;
      Ne:      cmpBit = aluA != aluB;
      Ge:      cmpBit = $signed(aluA) >= $signed(aluB);
      Geu:     cmpBit = aluA >= aluB;
      default: cmpBit = 1'b0;
    endcase
  end

  always_comb
  begin
    case (aluOp)
      Add:     aluResult = aluA + aluB;
      Sub:     aluResult = aluA - aluB;
      Sll:     aluResult = aluA << shamt;
      Xor:     aluResult = aluA ^ aluB;
      Srl:     aluResult = aluA >> shamt;
      Sra:     aluResult = $signed(aluA) >>> shamt;
      Or:      aluResult = aluA | aluB;
      And:     aluResult = aluA & aluB;
      default: aluResult = {{(XLEN-1){1'b0}}, cmpBit};  // Compares land in bit 0
    endcase
  end

endmodule

// ==== hw/controlSequencer.sv ====
`timescale 1ns/100ps

module controlSequencer (
  input  logic                         clk,
  input  logic                         reset,
  output corePkg::wbReqT               busReq,
  input  corePkg::wbRspT               busRsp,
  input  logic [rvIsaPkg::XLEN-1:0]    pc,
  output corePkg::pcCtrlT              pcCtrl,
  output rvIsaPkg::instrT              instr,
  input  logic [rvIsaPkg::XLEN-1:0]    imm,
  output rvIsaPkg::regIdxT             rs1Idx,
  output rvIsaPkg::regIdxT             rs2Idx,
  output rvIsaPkg::regIdxT             rdIdx,
  input  logic [rvIsaPkg::XLEN-1:0]    rs1Data,
  input  logic [rvIsaPkg::XLEN-1:0]    rs2Data,
  output logic                         wrEn,
  output logic [rvIsaPkg::XLEN-1:0]    wrData,
  output rvIsaPkg::aluOpT              aluOp,
  output logic [rvIsaPkg::XLEN-1:0]    aluA,
  output logic [rvIsaPkg::XLEN-1:0]    aluB,
  input  logic [rvIsaPkg::XLEN-1:0]    aluResult
);

  import rvIsaPkg::*;
  import corePkg::*;

  seqStateT        state;
  opcodeT          opcode;
  logic [2:0]      funct3;
  logic [XLEN-1:0] instrPc;                  // Address of the instruction in flight
  logic [XLEN-1:0] storeData;
  logic [XLEN-1:0] wbData;
  logic [XLEN-1:0] pcTarget;
  logic            wbEn;
  logic            pcLoad;
  logic            usesRs2;
  logic            misaligned;

  // Shared ALU selection for OP and OP-IMM
  function automatic aluOpT arithOp(input logic [2:0] f3, input logic subSel,
                                    input logic sraSel);
    aluOpT op;
    case (f3)
      F3AddSub: op = subSel ? Sub : Add;
      F3Sll:    op = Sll;
      F3Slt:    op = Slt;
      F3Sltu:   op = Sltu;
      F3Xor:    op = Xor;
      F3SrlSra: op = sraSel ? Sra : Srl;
      F3Or:     op = Or;
      F3And:    op = And;
      default:  op = Add;
    endcase
    return op;
  endfunction

  assign opcode     = instr.rType.opcode;
  assign funct3     = instr.rType.funct3;
  assign rs1Idx     = instr.rType.rs1;
  assign rs2Idx     = instr.rType.rs2;
  assign usesRs2    = (opcode == Op) || (opcode == Branch) || (opcode == Store);
  assign misaligned = aluResult[1:0] != 2'b00;  // Word accesses only

  assign wrEn   = (state == WriteBack) && wbEn;
  assign wrData = wbData;
  assign pcCtrl = '{inc:    (state == Fetch) && busReq.cyc && busRsp.ack,
                    load:   (state == WriteBack) && pcLoad,
                    target: pcTarget};

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state      <= Fetch;
      busReq.cyc <= 1'b0;
      busReq.stb <= 1'b0;
      busReq.we  <= 1'b0;
    end
    else
    begin
      case (state)
        Fetch:
        begin
          if (!busReq.cyc)
          begin
            busReq.cyc <= 1'b1;
            busReq.stb <= 1'b1;
            busReq.we  <= 1'b0;
            busReq.adr <= pc[XLEN-1:2];
          end
          else if (busRsp.ack)               // PC increments on this same edge
          begin
            busReq.cyc <= 1'b0;
            busReq.stb <= 1'b0;
            instr      <= busRsp.datR;
            instrPc    <= pc;
            state      <= Decode;
          end
        end
        Decode:
        begin
          case (opcode)
            OpImm:  aluOp <= arithOp(funct3, 1'b0, imm[10]);
            Op:     aluOp <= arithOp(funct3, instr.rType.funct7[5], instr.rType.funct7[5]);
            Branch:
            begin
              case (funct3)
                F3Bne:   aluOp <= Ne;
                F3Blt:   aluOp <= Slt;
                F3Bge:   aluOp <= Ge;
                F3Bltu:  aluOp <= Sltu;
                F3Bgeu:  aluOp <= Geu;
                F3Beq:   aluOp <= Eq;
                default: aluOp <= Eq;
              endcase
            end
            default: aluOp <= Add;           // Address and PC-relative sums
          endcase
          if (opcode == OpImm && (funct3 == F3Sll || funct3 == F3SrlSra))
            aluB <= {27'b0, imm[4:0]};       // Shift amount only
          else
            aluB <= imm;
          state <= ReadA;
        end
        ReadA:
        begin
          if (opcode == Auipc || opcode == Jal)
            aluA <= instrPc;
          else if (opcode == Lui)
            aluA <= '0;
          else
            aluA <= rs1Data;
          state <= usesRs2 ? ReadB : Execute;
        end
        ReadB:
        begin
          if (opcode == Store)
            storeData <= rs2Data;            // ALU still needs imm for the address
          else
            aluB <= rs2Data;
          state <= Execute;
        end
        Execute:
        begin
          rdIdx    <= instr.rType.rd;
          wbData   <= aluResult;
          wbEn     <= 1'b0;
          pcLoad   <= 1'b0;
          pcTarget <= aluResult;
          state    <= WriteBack;
          case (opcode)
            OpImm, Op, Lui, Auipc: wbEn <= 1'b1;
            Branch:
            begin
              pcLoad   <= aluResult[0];      // Branch decision
              pcTarget <= instrPc + imm;
            end
            Jal:
            begin
              wbEn   <= 1'b1;
              wbData <= pc;                  // Already instrPc + 4
              pcLoad <= 1'b1;
            end
            Jalr:
            begin
              wbEn     <= 1'b1;
              wbData   <= pc;
              pcLoad   <= 1'b1;
              pcTarget <= {aluResult[XLEN-1:1], 1'b0};
            end
            Load, Store:
            begin
              if (misaligned)                // Trap, no bus cycle
              begin
                wbEn     <= 1'b1;
                rdIdx    <= 5'd1;
                wbData   <= instrPc;
                pcLoad   <= 1'b1;
                pcTarget <= TrapAddress;
              end
              else
              begin
                busReq.cyc  <= 1'b1;
                busReq.stb  <= 1'b1;
                busReq.we   <= opcode == Store;
                busReq.adr  <= aluResult[XLEN-1:2];
                busReq.datW <= storeData;
                wbEn        <= opcode == Load;
                state       <= MemAccess;
              end
            end
            default: wbEn <= 1'b0;           // Unknown opcode retires as a no-op
          endcase
        end
        MemAccess:
        begin
          if (busRsp.ack)
          begin
            busReq.cyc <= 1'b0;
            busReq.stb <= 1'b0;
            busReq.we  <= 1'b0;
            wbData     <= busRsp.datR;       // Ignored for sw
            state      <= WriteBack;
          end
        end
        WriteBack: state <= Fetch;
        default:   state <= Fetch;
      endcase
    end
  end

endmodule

// ==== hw/corePkg.sv ====
package corePkg;

  localparam logic [rvIsaPkg::XLEN-1:0] ResetAddress = 32'h0000_0000;
  localparam logic [rvIsaPkg::XLEN-1:0] TrapAddress  = 32'h05EF_0DE0;  // Misaligned access handler

  // Wishbone classic master side
  typedef struct packed {
    logic                        cyc;
    logic                        stb;
    logic                        we;         // 1 => write, 0 => read
    logic [rvIsaPkg::XLEN-3:0]   adr;        // Word address
    logic [rvIsaPkg::XLEN-1:0]   datW;
  } wbReqT;

  // Wishbone classic slave side
  typedef struct packed {
    logic                        ack;
    logic [rvIsaPkg::XLEN-1:0]   datR;
  } wbRspT;

  // Program counter control from the sequencer
  typedef struct packed {
    logic                        inc;        // PC += 4
    logic                        load;       // PC <= target, wins over inc
    logic [rvIsaPkg::XLEN-1:0]   target;
  } pcCtrlT;

  // Sequencer states, one instruction in flight
  typedef enum logic [3:0] {
    Fetch     = 4'h0,                        // Bus read at PC, ends on ack
    Decode    = 4'h1,
    ReadA     = 4'h2,                        // Latch first operand
    ReadB     = 4'h3,                        // Only for rs2 users
    Execute   = 4'h4,
    MemAccess = 4'h5,                        // lw/sw bus cycle
    WriteBack = 4'h6
  } seqStateT;

endpackage

// ==== hw/immDecoder.sv ====
`timescale 1ns/100ps

module immDecoder (
  input  rvIsaPkg::instrT              instr,
  output logic [rvIsaPkg::XLEN-1:0]    imm
);

  import rvIsaPkg::*;

  always_comb
  begin
    case (instr.rType.opcode)
      OpImm, Jalr, Load:                     // I format
        imm = {{20{instr.iType.imm[11]}}, instr.iType.imm};
      Store:                                 // S format
        imm = {{20{instr.sType.immHi[6]}}, instr.sType.immHi, instr.sType.immLo};
      Branch:                                // B format, always even
        imm = {{19{instr.bType.immSign}}, instr.bType.immSign, instr.bType.immBit11,
               instr.bType.immMid, instr.bType.immLow, 1'b0};
      Lui, Auipc:                            // U format
        imm = {instr.uType.imm, 12'b0};
      Jal:                                   // J format
        imm = {{11{instr.jType.immSign}}, instr.jType.immSign, instr.jType.immHigh,
               instr.jType.immBit11, instr.jType.immLow, 1'b0};
      default:
        imm = '0;
    endcase
  end

endmodule

// ==== hw/programCounter.sv ====
`timescale 1ns/100ps

module programCounter (
  input  logic                         clk,
  input  logic                         reset,
  input  corePkg::pcCtrlT              pcCtrl,
  output logic [rvIsaPkg::XLEN-1:0]    pc
);

  import corePkg::*;

  always_ff @(posedge clk)
  begin
    if (reset)
      pc <= ResetAddress;
    else if (pcCtrl.load)                    // Jumps, taken branches, trap
      pc <= pcCtrl.target;
    else if (pcCtrl.inc)                     // Sequential fetch
      pc <= pc + 32'd4;
  end

endmodule

// ==== hw/regBank.sv ====
`timescale 1ns/100ps

module regBank (
  input  logic                         clk,
  input  rvIsaPkg::regIdxT             rs1Idx,
  input  rvIsaPkg::regIdxT             rs2Idx,
  input  rvIsaPkg::regIdxT             rdIdx,
  input  logic                         wrEn,
  input  logic [rvIsaPkg::XLEN-1:0]    wrData,
  output logic [rvIsaPkg::XLEN-1:0]    rs1Data,
  output logic [rvIsaPkg::XLEN-1:0]    rs2Data
);

  import rvIsaPkg::*;

  logic [XLEN-1:0] regs [1:31];              // x0 has no storage

  always_ff @(posedge clk)
  begin
    if (wrEn && (rdIdx != 5'd0))
      regs[rdIdx] <= wrData;
  end

  // Asynchronous reads, x0 hardwired to zero
  assign rs1Data = (rs1Idx == 5'd0) ? '0 : regs[rs1Idx];
  assign rs2Data = (rs2Idx == 5'd0) ? '0 : regs[rs2Idx];

endmodule

// ==== hw/rvCore.sv ====
`timescale 1ns/100ps

module rvCore (
  input  logic            clk,
  input  logic            reset,
  output corePkg::wbReqT  busReq,
  input  corePkg::wbRspT  busRsp
);

  import rvIsaPkg::*;
  import corePkg::*;

  logic [XLEN-1:0] pc;
  pcCtrlT          pcCtrl;
  instrT           instr;
  logic [XLEN-1:0] imm;
  regIdxT          rs1Idx;
  regIdxT          rs2Idx;
  regIdxT          rdIdx;
  logic [XLEN-1:0] rs1Data;
  logic [XLEN-1:0] rs2Data;
  logic            wrEn;
  logic [XLEN-1:0] wrData;
  aluOpT           aluOp;
  logic [XLEN-1:0] aluA;
  logic [XLEN-1:0] aluB;
  logic [XLEN-1:0] aluResult;

  controlSequencer u_sequencer (
    .clk(clk), .reset(reset),
    .busReq(busReq), .busRsp(busRsp),
    .pc(pc), .pcCtrl(pcCtrl),
    .instr(instr), .imm(imm),
    .rs1Idx(rs1Idx), .rs2Idx(rs2Idx), .rdIdx(rdIdx),
    .rs1Data(rs1Data), .rs2Data(rs2Data),
    .wrEn(wrEn), .wrData(wrData),
    .aluOp(aluOp), .aluA(aluA), .aluB(aluB), .aluResult(aluResult)
  );

  programCounter u_programCounter (
    .clk(clk), .reset(reset), .pcCtrl(pcCtrl), .pc(pc)
  );

  regBank u_regBank (
    .clk(clk),
    .rs1Idx(rs1Idx), .rs2Idx(rs2Idx), .rdIdx(rdIdx),
    .wrEn(wrEn), .wrData(wrData),
    .rs1Data(rs1Data), .rs2Data(rs2Data)
  );

  aluUnit u_aluUnit (
    .aluOp(aluOp), .aluA(aluA), .aluB(aluB), .aluResult(aluResult)
  );

  immDecoder u_immDecoder (
    .instr(instr), .imm(imm)
  );

endmodule

// ==== hw/rvIsaPkg.sv ====
package rvIsaPkg;

  localparam int XLEN = 32;                  // Data and address width

  typedef logic [4:0] regIdxT;

  // Major opcodes of the supported RV32I subset
  typedef enum logic [6:0] {
    OpImm  = 7'b0010011,
    Op     = 7'b0110011,
    Branch = 7'b1100011,
    Lui    = 7'b0110111,
    Auipc  = 7'b0010111,
    Jal    = 7'b1101111,
    Jalr   = 7'b1100111,
    Load   = 7'b0000011,
    Store  = 7'b0100011
  } opcodeT;

  // funct3 for OP and OP-IMM
  localparam logic [2:0] F3AddSub = 3'b000;
  localparam logic [2:0] F3Sll    = 3'b001;
  localparam logic [2:0] F3Slt    = 3'b010;
  localparam logic [2:0] F3Sltu   = 3'b011;
  localparam logic [2:0] F3Xor    = 3'b100;
  localparam logic [2:0] F3SrlSra = 3'b101;
  localparam logic [2:0] F3Or     = 3'b110;
  localparam logic [2:0] F3And    = 3'b111;

  // funct3 for conditional branches
  localparam logic [2:0] F3Beq    = 3'b000;
  localparam logic [2:0] F3Bne    = 3'b001;
  localparam logic [2:0] F3Blt    = 3'b100;
  localparam logic [2:0] F3Bge    = 3'b101;
  localparam logic [2:0] F3Bltu   = 3'b110;
  localparam logic [2:0] F3Bgeu   = 3'b111;

  typedef enum logic [3:0] {
    Add, Sub, Sll, Slt, Sltu, Xor, Srl, Sra, Or, And,
    Eq, Ne, Ge, Geu                          // Branch compares, result in bit 0
  } aluOpT;

  typedef struct packed {
    logic [6:0] funct7;
    regIdxT     rs2;
    regIdxT     rs1;
    logic [2:0] funct3;
    regIdxT     rd;
    opcodeT     opcode;
  } rTypeT;

  typedef struct packed {
    logic [11:0] imm;
    regIdxT      rs1;
    logic [2:0]  funct3;
    regIdxT      rd;
    opcodeT      opcode;
  } iTypeT;

  typedef struct packed {
    logic [6:0] immHi;                       // imm[11:5]
    regIdxT     rs2;
    regIdxT     rs1;
    logic [2:0] funct3;
    logic [4:0] immLo;                       // imm[4:0]
    opcodeT     opcode;
  } sTypeT;

  typedef struct packed {
    logic       immSign;                     // imm[12]
    logic [5:0] immMid;                      // imm[10:5]
    regIdxT     rs2;
    regIdxT     rs1;
    logic [2:0] funct3;
    logic [3:0] immLow;                      // imm[4:1]
    logic       immBit11;
    opcodeT     opcode;
  } bTypeT;

  typedef struct packed {
    logic [19:0] imm;                        // imm[31:12]
    regIdxT      rd;
    opcodeT      opcode;
  } uTypeT;

  typedef struct packed {
    logic       immSign;                     // imm[20]
    logic [9:0] immLow;                      // imm[10:1]
    logic       immBit11;
    logic [7:0] immHigh;                     // imm[19:12]
    regIdxT     rd;
    opcodeT     opcode;
  } jTypeT;

  // One instruction word seen through each encoding format
  typedef union packed {
    rTypeT rType;
    iTypeT iType;
    sTypeT sType;
    bTypeT bType;
    uTypeT uType;
    jTypeT jType;
  } instrT;

endpackage
